//--- src.f
+incdir+sim
common/fp_formats_pkg.sv
common/conv_op_pkg.sv
bf16_conversion/bf16_to_fp32.sv
bf16_conversion/fp32_to_bf16.sv
bf16_conversion/bf16_conversion.sv
sim/tb_bf16_conversion.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the BF16 conversion testbench with Verilator
set -e

cd "$(dirname "$0")"

TOP=tb_bf16_conversion
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --top-module "$TOP" -f src.f

# A failing run exits nonzero, the log decides the verdict
./obj_dir/V"$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    exit 0
else
    echo "simulation did not pass, see $LOG"
    exit 1
fi

//--- sim/conv_model.svh
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// Expected {flags, result} for a BF16 value in the low half of the word
function automatic logic [35:0] ref_bf16_to_fp32(input logic [31:0] word);
    logic [15:0] bf;
    logic [31:0] res;
    logic [3:0]  flags;
    bf    = word[15:0];
    flags = 4'h0;
    if (bf[14:7] == EXP_MAX && bf[6:0] != 7'h00) begin
        // Any NaN comes out quiet with its sign
        res            = FP32_QNAN | {bf[15], 31'h0};
        // Signaling when the top mantissa bit is clear
        flags[FLAG_NV] = ~bf[6];
    end else begin
        // Same exponent, wider mantissa, exact
        res = {bf, 16'h0000};
    end
    return {flags, res};
endfunction

// Expected {flags, result} for FP32 narrowed to BF16, zero-extended
function automatic logic [35:0] ref_fp32_to_bf16(input logic [31:0] word);
    logic [15:0] upper;
    logic [15:0] lower;
    logic [15:0] res;
    logic [3:0]  flags;
    logic        inc;
    upper = word[31:16];
    lower = word[15:0];
    flags = 4'h0;
    if (word[30:23] == EXP_MAX) begin
        // NaN quieted, infinity kept as is
        res            = (word[22:0] != 23'h0) ? (BF16_QNAN | {word[31], 15'h0}) : upper;
        flags[FLAG_NV] = (word[22:0] != 23'h0) & ~word[22];
    end else begin
        // Past halfway, or exactly halfway with an odd kept LSB
        inc = (lower > 16'h8000) || (lower == 16'h8000 && upper[0]);
        // Upper half plus one carries into the exponent on its own
        res            = upper + {15'h0, inc};
        flags[FLAG_OF] = (res[14:7] == EXP_MAX);
        flags[FLAG_NX] = (lower != 16'h0000) || (res[14:7] == EXP_MAX);
        flags[FLAG_UF] = (res[14:7] == 8'h00) && (lower != 16'h0000);
    end
    return {flags, 16'h0000, res};
endfunction

`endif

//--- sim/tb_bf16_conversion.sv
`default_nettype none

module tb_bf16_conversion
    import fp_formats_pkg::*;
    import conv_op_pkg::*;
();

    `include "conv_model.svh"

    localparam int unsigned NUM_OPS     = 2000;
    localparam int unsigned CYCLE_LIMIT = NUM_OPS * 8 + 100;
    localparam logic [31:0] SEED        = 32'h5b1c_a375;

    logic        clk;
    logic        arst_n_i;
    logic        enable_i;
    logic [3:0]  operation_i;
    logic [31:0] operand_i;
    logic        in_valid_i;
    logic        in_ready_o;
    logic        out_valid_o;
    logic        out_ready_i;
    logic [31:0] result_o;
    logic [3:0]  fpcsr_o;

    // Expected {flags, result} in acceptance order
    logic [35:0] expect_q[$];
    int unsigned cycle_count = 0;
    int unsigned sent;
    logic        fired_last;
    // Mode applied on each falling edge
    logic        mode_en;
    logic [3:0]  mode_op;
    logic [31:0] rnd;

    bf16_conversion dut (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .enable_i    (enable_i),
        .operation_i (operation_i),
        .operand_i   (operand_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .result_o    (result_o),
        .fpcsr_o     (fpcsr_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [35:0] expected,
                               input logic [35:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("mismatch %s: expected %h actual %h",
                                     name, expected, actual));
        end
    endtask

    // Cycle limit from the operand count, with slack for stalls
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            report_failure("timeout: cycle limit reached before all operands finished");
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////

    // Random word or crafted special, halves swapped for BF16 input
    function automatic logic [31:0] make_operand(input logic to_bf16);
        logic [31:0] word;
        logic [31:0] pick;
        word = $urandom;
        pick = $urandom;
        case (pick[3:0])
            4'd0: word = {pick[31], 31'h0};
            4'd1: word = {pick[31], 8'hFF, 23'h0};
            // NaN, quiet bit random, mantissa never zero in either view
            4'd2, 4'd3: word = {pick[31], 8'hFF, pick[4], word[21:17], 1'b1, word[15:0]};
            // Subnormals and the smallest normals
            4'd4, 4'd5: word = {pick[31], 7'h00, pick[5], word[22:0]};
            // Exact ties, kept LSB random
            4'd6, 4'd7: word = {word[31:16], 16'h8000};
            // Close to the largest finite BF16
            4'd8: word = {pick[31], 8'hFE, 6'h3F, pick[5], word[15:0]};
            default: word = word;
        endcase
        return to_bf16 ? word : {word[15:0], word[31:16]};
    endfunction

    // One cycle of traffic with a sample just after the falling edge
    task automatic run_cycle(input logic vld, input logic [31:0] operand);
        string name;
        @(negedge clk);
        enable_i    = mode_en;
        operation_i = mode_op;
        in_valid_i  = vld;
        operand_i   = operand;
        out_ready_i = ($urandom_range(0, 2) != 0);
        #1;
        if (mode_op == OP_FP32_TO_BF16) begin
            name = "fp32_to_bf16";
        end else begin
            name = "bf16_to_fp32";
        end
        // Latency of exactly one cycle
        if (fired_last && !out_valid_o) begin
            report_failure("no result one cycle after an accepted operand");
        end
        if (out_valid_o && !out_ready_i && in_ready_o) begin
            report_failure("in_ready_o high while a result waits");
        end
        if (out_valid_o && out_ready_i) begin
            if (expect_q.size() == 0) begin
                report_failure("result delivered with no operand pending");
            end
            check_value(name, expect_q.pop_front(), {fpcsr_o, result_o});
        end
        fired_last = vld & in_ready_o;
        if (fired_last) begin
            if (mode_op == OP_FP32_TO_BF16) begin
                expect_q.push_back(ref_fp32_to_bf16(operand));
            end else begin
                expect_q.push_back(ref_bf16_to_fp32(operand));
            end
        end
    endtask

    // Unselected cycle, handshake and result read as zero
    task automatic idle_cycle();
        logic [31:0] bits;
        bits = $urandom;
        @(negedge clk);
        enable_i    = mode_en;
        operation_i = mode_op;
        in_valid_i  = bits[0];
        out_ready_i = bits[1];
        operand_i   = $urandom;
        #1;
        check_value("idle handshake", 36'h0, {34'h0, in_ready_o, out_valid_o});
        check_value("idle result", 36'h0, {fpcsr_o, result_o});
    endtask

    // Send a run of operands in one direction, then drain
    task automatic send_batch(input int unsigned count);
        int unsigned done;
        logic        have;
        logic [31:0] word;
        logic [31:0] bits;
        done = 0;
        have = 1'b0;
        word = 32'h0;
        while (done < count) begin
            bits = $urandom;
            // Valid drops now and then between operands
            if (!have && bits[1:0] != 2'b00) begin
                word = make_operand(mode_op == OP_FP32_TO_BF16);
                have = 1'b1;
            end
            run_cycle(have, word);
            if (fired_last) begin
                have = 1'b0;
                done++;
            end
        end
        while (expect_q.size() != 0) begin
            run_cycle(1'b0, word);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        arst_n_i    = 1'b0;
        enable_i    = 1'b0;
        operation_i = 4'h0;
        operand_i   = 32'h0;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        mode_en     = 1'b0;
        mode_op     = 4'h0;
        sent        = 0;
        fired_last  = 1'b0;
        repeat (4) @(negedge clk);
        arst_n_i = 1'b1;
        while (sent < NUM_OPS) begin
            rnd = $urandom;
            if (rnd[2:0] == 3'd0) begin
                // Enable low, or an unsupported opcode
                mode_en = rnd[3];
                mode_op = rnd[3] ? (rnd[7:4] | 4'h2) : rnd[7:4];
                repeat (4) idle_cycle();
            end else begin
                mode_en = 1'b1;
                mode_op = rnd[3] ? OP_FP32_TO_BF16 : OP_BF16_TO_FP32;
                send_batch((1 + rnd[7:4] < NUM_OPS - sent) ? 1 + rnd[7:4] : NUM_OPS - sent);
                sent = sent + ((1 + rnd[7:4] < NUM_OPS - sent) ? 1 + rnd[7:4] : NUM_OPS - sent);
            end
        end
        if (expect_q.size() == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_failure("results still pending at the end of the run");
        end
    end

endmodule

`default_nettype wire

//--- bf16_conversion/bf16_conversion.sv
`default_nettype none

module bf16_conversion
    import fp_formats_pkg::*;
    import conv_op_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n_i,
    // Operation select
    input  wire logic        enable_i,
    input  wire logic [3:0]  operation_i,
    // Shared operand for both directions
    input  wire logic [31:0] operand_i,
    // Input handshake
    input  wire logic        in_valid_i,
    output logic             in_ready_o,
    // Output handshake
    output logic             out_valid_o,
    input  wire logic        out_ready_i,
    // Result with BF16 results zero-extended
    output logic [31:0]      result_o,
    output logic [3:0]       fpcsr_o
);

    // Operand decoded through the union inside each converter
    fp_word_u    operand_w;

    // Converter selects
    logic        sel_b2f;
    logic        sel_f2b;

    // Gated strobes toward each converter
    logic        b2f_in_valid;
    logic        b2f_out_ready;
    logic        f2b_in_valid;
    logic        f2b_out_ready;

    // Converter returns
    logic        b2f_in_ready;
    logic        b2f_out_valid;
    logic [31:0] b2f_result;
    logic [3:0]  b2f_flags;
    logic        f2b_in_ready;
    logic        f2b_out_valid;
    logic [15:0] f2b_result;
    logic [3:0]  f2b_flags;

    assign operand_w = operand_i;

    //////////////////////////////////////////////////////////////////////
    // Dispatch
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_b2f = enable_i & (operation_i == OP_BF16_TO_FP32);
        sel_f2b = enable_i & (operation_i == OP_FP32_TO_BF16);

        // Unselected converter sees an idle bus
        b2f_in_valid  = in_valid_i  & sel_b2f;
        b2f_out_ready = out_ready_i & sel_b2f;
        f2b_in_valid  = in_valid_i  & sel_f2b;
        f2b_out_ready = out_ready_i & sel_f2b;
    end

    always_comb begin
        // Handshake back from whichever converter owns the bus
        in_ready_o  = sel_b2f ? b2f_in_ready  : (sel_f2b ? f2b_in_ready  : 1'b0);
        out_valid_o = sel_b2f ? b2f_out_valid : (sel_f2b ? f2b_out_valid : 1'b0);

        // Result mux reads zero when no direction is active
        result_o = sel_b2f ? b2f_result : (sel_f2b ? {16'h0000, f2b_result} : 32'h0);
        fpcsr_o  = sel_b2f ? b2f_flags  : (sel_f2b ? f2b_flags : 4'h0);
    end

    //////////////////////////////////////////////////////////////////////
    // Converters
    //////////////////////////////////////////////////////////////////////

    bf16_to_fp32 u_bf16_to_fp32 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .operand_i   (operand_w),
        .in_valid_i  (b2f_in_valid),
        .in_ready_o  (b2f_in_ready),
        .out_valid_o (b2f_out_valid),
        .out_ready_i (b2f_out_ready),
        .result_o    (b2f_result),
        .fpcsr_o     (b2f_flags)
    );

    fp32_to_bf16 u_fp32_to_bf16 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .operand_i   (operand_w),
        .in_valid_i  (f2b_in_valid),
        .in_ready_o  (f2b_in_ready),
        .out_valid_o (f2b_out_valid),
        .out_ready_i (f2b_out_ready),
        .result_o    (f2b_result),
        .fpcsr_o     (f2b_flags)
    );

endmodule

`default_nettype wire

//--- bf16_conversion/fp32_to_bf16.sv
`default_nettype none

module fp32_to_bf16
    import fp_formats_pkg::*;
    import conv_op_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    // Operand, read through the FP32 view
    input  wire fp_word_u operand_i,
    // Input handshake
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    // Output handshake
    output logic          out_valid_o,
    input  wire logic     out_ready_i,
    // Registered BF16 result and flags
    output logic [15:0]   result_o,
    output logic [3:0]    fpcsr_o
);

    // Mantissa bits that do not fit in BF16
    localparam int unsigned DROP_W = FP32_MAN_W - BF16_MAN_W;

    logic                             in_fire;
    logic                             is_nan;
    logic                             is_inf;
    logic [BF16_MAN_W-1:0]            kept_man;
    logic                             guard_bit;
    logic                             round_bit;
    logic                             sticky_bit;
    logic                             inexact;
    logic                             round_up;
    logic [BF16_EXP_W+BF16_MAN_W-1:0] rounded;
    logic [BF16_EXP_W-1:0]            rounded_exp;
    logic [15:0]                      result_d;
    logic [3:0]                       flags_d;

    // Stage takes a new operand when empty or when its result leaves now
    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    //////////////////////////////////////////////////////////////////////
    // Round to nearest, ties to even
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        is_nan = (operand_i.fp32.exponent == EXP_MAX) && (operand_i.fp32.mantissa != '0);
        is_inf = (operand_i.fp32.exponent == EXP_MAX) && (operand_i.fp32.mantissa == '0);

        // Top mantissa bits survive
        kept_man   = operand_i.fp32.mantissa[FP32_MAN_W-1 -: BF16_MAN_W];
        // First dropped bit, next one, then the OR of the rest
        guard_bit  = operand_i.fp32.mantissa[DROP_W-1];
        round_bit  = operand_i.fp32.mantissa[DROP_W-2];
        sticky_bit = |operand_i.fp32.mantissa[DROP_W-3:0];
        inexact    = guard_bit | round_bit | sticky_bit;

        // Above half rounds up; exactly half rounds up only from an odd LSB
        round_up = guard_bit & (round_bit | sticky_bit | kept_man[0]);

        // Exponent and mantissa added as one field so a carry bumps the exponent
        rounded     = {operand_i.fp32.exponent, kept_man}
                      + {{(BF16_EXP_W + BF16_MAN_W - 1){1'b0}}, round_up};
        rounded_exp = rounded[BF16_EXP_W+BF16_MAN_W-1 -: BF16_EXP_W];

        flags_d = '0;
        if (is_nan) begin
            // Quiet NaN out, sign kept, invalid only for signaling input
            result_d         = {operand_i.fp32.sign, BF16_QNAN[14:0]};
            flags_d[FLAG_NV] = ~operand_i.fp32.mantissa[FP32_MAN_W-1];
        end else if (is_inf) begin
            // Infinity passes through unchanged
            result_d = {operand_i.fp32.sign, EXP_MAX, {BF16_MAN_W{1'b0}}};
        end else begin
            // Carry into 255 already leaves a zero mantissa, i.e. signed infinity
            result_d         = {operand_i.fp32.sign, rounded};
            flags_d[FLAG_NX] = inexact;
            if (rounded_exp == EXP_MAX) begin
                flags_d[FLAG_OF] = 1'b1;
                flags_d[FLAG_NX] = 1'b1;
            end
            // Tiny after rounding and not exact
            flags_d[FLAG_UF] = (rounded_exp == '0) & inexact;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    // Valid follows the input whenever the stage can move
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    // Payload holds under back-pressure
    always_ff @(posedge clk) begin
        if (in_fire) begin
            result_o <= result_d;
            fpcsr_o  <= flags_d;
        end
    end

endmodule

`default_nettype wire

//--- bf16_conversion/bf16_to_fp32.sv
`default_nettype none

module bf16_to_fp32
    import fp_formats_pkg::*;
    import conv_op_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n_i,
    // Operand, only the BF16 view is read
    input  wire fp_word_u operand_i,
    // Input handshake
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    // Output handshake
    output logic          out_valid_o,
    input  wire logic     out_ready_i,
    // Registered result and flags
    output logic [31:0]   result_o,
    output logic [3:0]    fpcsr_o
);

    logic        in_fire;
    logic        is_nan;
    logic [31:0] result_d;
    logic [3:0]  flags_d;

    // Stage takes a new operand when empty or when its result leaves now
    assign in_ready_o = ~out_valid_o | out_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    //////////////////////////////////////////////////////////////////////
    // Widening
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        is_nan  = (operand_i.bf16.exponent == EXP_MAX) && (operand_i.bf16.mantissa != '0);
        flags_d = '0;
        if (is_nan) begin
            // Any NaN leaves as the canonical quiet NaN, sign kept
            result_d         = {operand_i.bf16.sign, FP32_QNAN[30:0]};
            // Quiet bit clear means signaling
            flags_d[FLAG_NV] = ~operand_i.bf16.mantissa[BF16_MAN_W-1];
        end else begin
            // Same exponent range, so just pad the mantissa with zeros
            result_d = {operand_i.bf16.sign,
                        operand_i.bf16.exponent,
                        operand_i.bf16.mantissa,
                        {(FP32_MAN_W - BF16_MAN_W){1'b0}}};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output stage
    //////////////////////////////////////////////////////////////////////

    // Valid follows the input whenever the stage can move
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    // Payload holds under back-pressure
    always_ff @(posedge clk) begin
        if (in_fire) begin
            result_o <= result_d;
            fpcsr_o  <= flags_d;
        end
    end

endmodule

`default_nettype wire

//--- common/conv_op_pkg.sv
`default_nettype none

package conv_op_pkg;

    //////////////////////////////////////////////////////////////////////
    // Operation codes
    //////////////////////////////////////////////////////////////////////

    // Widen BF16 to FP32, always exact
    localparam logic [3:0] OP_BF16_TO_FP32 = 4'd0;

    // Narrow FP32 to BF16, round to nearest even
    localparam logic [3:0] OP_FP32_TO_BF16 = 4'd1;

    // Any other opcode is unsupported and leaves both converters idle

    //////////////////////////////////////////////////////////////////////
    // Status word bit positions
    //////////////////////////////////////////////////////////////////////

    // Inexact
    localparam int unsigned FLAG_NX = 0;
    // Underflow, tiny and inexact
    localparam int unsigned FLAG_UF = 1;
    // Overflow to infinity
    localparam int unsigned FLAG_OF = 2;
    // Invalid, signaling NaN seen
    localparam int unsigned FLAG_NV = 3;

endpackage

`default_nettype wire

//--- common/fp_formats_pkg.sv
`default_nettype none

package fp_formats_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////////////////////////

    // IEEE-754 single precision
    localparam int unsigned FP32_EXP_W = 8;
    localparam int unsigned FP32_MAN_W = 23;

    // Brain float, same exponent range as FP32 with a short mantissa
    localparam int unsigned BF16_EXP_W = 8;
    localparam int unsigned BF16_MAN_W = 7;

    //////////////////////////////////////////////////////////////////////
    // Special encodings
    //////////////////////////////////////////////////////////////////////

    // All-ones exponent marks infinity and NaN in both formats
    localparam logic [FP32_EXP_W-1:0] EXP_MAX = 8'hFF;

    // Canonical quiet NaNs, sign cleared so the converter can insert it
    localparam logic [15:0] BF16_QNAN = 16'h7FC0;
    localparam logic [31:0] FP32_QNAN = 32'h7FC0_0000;

    //////////////////////////////////////////////////////////////////////
    // Operand views
    //////////////////////////////////////////////////////////////////////

    // FP32 word, full 32 bits
    typedef struct packed {
        logic                  sign;
        logic [FP32_EXP_W-1:0] exponent;
        logic [FP32_MAN_W-1:0] mantissa;
    } fp32_fields_t;

    // BF16 value sitting in the low half of the operand word
    typedef struct packed {
        logic [15:0]           unused;
        logic                  sign;
        logic [BF16_EXP_W-1:0] exponent;
        logic [BF16_MAN_W-1:0] mantissa;
    } bf16_fields_t;

    // Same 32-bit operand, decoded per direction
    typedef union packed {
        fp32_fields_t fp32;
        bf16_fields_t bf16;
    } fp_word_u;

endpackage

`default_nettype wire
